//--- filelist.f
hw/mnist_pkg.sv
hw/spram.sv
hw/param_store.sv
hw/mac_array.sv
hw/requant_relu.sv
hw/layer_sequencer.sv
hw/argmax_scan.sv
hw/mnist_accel_top.sv
tb/tb_clock_gen.sv
tb/mnist_accel_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mnist_accel_tb \
    -f filelist.f -o sim_mnist > build.log 2>&1 \
    || { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/sim_mnist > sim.log 2>&1 || sim_err=1
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
[ -z "$sim_err" ] || { echo "Simulator exited with an error"; exit 1; }
echo "Simulation clean"
exit 0

//--- tb/mnist_accel_tb.sv
// Inputs change on rising edges, outputs are read on falling edges; a run may take 20000 cycles
`timescale 1ns/1ns
module mnist_accel_tb;

    logic                    clk;
    logic                    reset;
    mnist_pkg::host_wr_t     host_wr;
    logic                    start;
    mnist_pkg::requant_cfg_t requant;
    logic                    busy;
    logic                    done;
    logic [3:0]              class_idx;
    logic signed [31:0]      class_val;

    // --------------------
    // Shadow copies of everything the host wrote
    logic [7:0]        act_m [mnist_pkg::K_L1];
    logic signed [7:0] w1_m  [mnist_pkg::K_L2][mnist_pkg::K_L1];
    int                b1_m  [mnist_pkg::K_L2];
    logic signed [7:0] w2_m  [mnist_pkg::LANES][mnist_pkg::K_L2];
    int                b2_m  [mnist_pkg::LANES];

    logic [31:0]        lfsr;
    string              cur_test;
    int                 test_errs;
    int                 tests_run;
    int                 tests_bad;
    int                 total_errs;
    logic [3:0]         got_idx;
    logic signed [31:0] got_val;
    int                 tie_bias;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    mnist_accel_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .i_host_wr   (host_wr),
        .i_start     (start),
        .i_requant   (requant),
        .o_busy      (busy),
        .o_done      (done),
        .o_class_idx (class_idx),
        .o_class_val (class_val)
    );

    // --------------------
    // Random source with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // --------------------
    // Host bus
    task automatic host_write(input logic [19:0] addr, input logic [31:0] data);
        @(posedge clk);
        host_wr <= '{wren: 1'b1, addr: addr, data: data};
    endtask

    task automatic idle_bus();
        @(posedge clk);
        host_wr <= '0;
    endtask

    task automatic load_act();
        for (int k = 0; k < mnist_pkg::K_L1; k++) begin
            act_m[k] = 8'(rand_bits(8));
            host_write(mnist_pkg::ACT_H_BASE + 20'(k), 32'(act_m[k]));
        end
        idle_bus();
    endtask

    // Neuron n lives in bank n % 10 at word (n / 10) * 64 + k
    task automatic load_layer1();
        for (int n = 0; n < mnist_pkg::K_L2; n++) begin
            for (int k = 0; k < mnist_pkg::K_L1; k++) begin
                w1_m[n][k] = 8'(rand_bits(8));
                host_write(mnist_pkg::W1_H_BASE + 20'((n % 10) * 4096 + (n / 10) * 64 + k),
                           32'(w1_m[n][k]));
            end
            b1_m[n] = int'(rand_bits(17)) - 65536;
            host_write(mnist_pkg::B1_H_BASE + 20'(n), b1_m[n]);
        end
        idle_bus();
    endtask

    task automatic load_layer2(input bit zero_weights, input bit equal_bias);
        tie_bias = int'(rand_bits(17)) - 65536;
        for (int c = 0; c < mnist_pkg::LANES; c++) begin
            for (int k = 0; k < mnist_pkg::K_L2; k++) begin
                w2_m[c][k] = zero_weights ? 8'sd0 : 8'(rand_bits(8));
                host_write(mnist_pkg::W2_H_BASE + 20'(c * 4096 + k), 32'(w2_m[c][k]));
            end
            b2_m[c] = equal_bias ? tie_bias : int'(rand_bits(17)) - 65536;
            host_write(mnist_pkg::B2_H_BASE + 20'(c), b2_m[c]);
        end
        idle_bus();
    endtask

    // --------------------
    // Reference model
    task automatic compute_model(input mnist_pkg::requant_cfg_t cfg,
                                 output logic [3:0] idx, output int val);
        int     acc;
        longint scaled;
        int     hid   [mnist_pkg::K_L2];
        int     logit [mnist_pkg::LANES];
        for (int n = 0; n < mnist_pkg::K_L2; n++) begin
            acc = b1_m[n];
            for (int k = 0; k < mnist_pkg::K_L1; k++) begin
                acc += int'(act_m[k]) * int'(w1_m[n][k]);
            end
            if (acc < 0) begin
                acc = 0;
            end
            scaled = (longint'(acc) * longint'(cfg.mult)) >>> cfg.shift;
            hid[n] = (scaled > 255) ? 255 : int'(scaled);
        end
        idx = '0;
        for (int c = 0; c < mnist_pkg::LANES; c++) begin
            logit[c] = b2_m[c];
            for (int k = 0; k < mnist_pkg::K_L2; k++) begin
                logit[c] += hid[k] * int'(w2_m[c][k]);
            end
            // Strict compare keeps the lowest index on ties
            if (c > 0 && logit[c] > logit[idx]) begin
                idx = 4'(c);
            end
        end
        val = logit[idx];
    endtask

    // --------------------
    // Checks and reporting
    task automatic check_eq(input string what, input longint exp, input longint act);
        assert (exp == act) else begin
            $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: %0d error(s)", cur_test, test_errs);
        end
    endtask

    // Start pulse, optional W2 writes while busy, then wait for done
    task automatic run_inference(input mnist_pkg::requant_cfg_t cfg, input int noise);
        int         cycles;
        bit         seen;
        logic [3:0] bank;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        start   <= 1'b1;
        requant <= cfg;
        @(posedge clk);
        start <= 1'b0;
        while (!seen && cycles < 20000) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
                assert (!busy) else begin
                    $display("In %s busy was still high in the done cycle", cur_test);
                    test_errs++;
                end
            end else begin
                assert (busy) else begin
                    $display("In %s busy was low %0d cycles after start", cur_test, cycles);
                    test_errs++;
                end
            end
            if (!seen) begin
                @(posedge clk);
                if (cycles < noise) begin
                    bank = 4'(rand_bits(4) % 10);
                    host_wr <= '{wren: 1'b1,
                                 addr: mnist_pkg::W2_H_BASE + (20'(bank) << 12)
                                       + 20'(rand_bits(7) % 100),
                                 data: rand_bits(32)};
                end else begin
                    host_wr <= '0;
                end
            end
        end
        assert (seen) else begin
            $display("In %s done never came within 20000 cycles", cur_test);
            test_errs++;
        end
        got_idx = class_idx;
        got_val = class_val;
    endtask

    task automatic run_and_check(input mnist_pkg::requant_cfg_t cfg, input int noise);
        logic [3:0] exp_idx;
        int         exp_val;
        compute_model(cfg, exp_idx, exp_val);
        run_inference(cfg, noise);
        check_eq("class_idx", exp_idx, got_idx);
        check_eq("class_val", exp_val, got_val);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset !== 1'b0 && n < 100);
        assert (reset === 1'b0) else begin
            $display("Reset was never released");
            test_errs++;
        end
    endtask

    // --------------------
    // Test sequence
    initial begin
        host_wr <= '0;
        start   <= 1'b0;
        requant <= '0;
        lfsr       = 32'h8309;
        tests_run  = 0;
        tests_bad  = 0;
        total_errs = 0;

        begin_test("reset_state");
        wait_reset_release();
        @(negedge clk);
        check_eq("busy", 0, busy);
        check_eq("done", 0, done);
        check_eq("class_idx", 0, class_idx);
        check_eq("class_val", 0, class_val);
        finish_test();

        begin_test("random_inference");
        load_act();
        load_layer1();
        load_layer2(1'b0, 1'b0);
        run_and_check('{mult: 16'd100, shift: 5'd16}, 0);
        finish_test();

        // Any positive sum lands far above 255
        begin_test("saturation_relu");
        load_layer1();
        load_layer2(1'b0, 1'b0);
        run_and_check('{mult: 16'hFFFF, shift: 5'd4}, 0);
        finish_test();

        begin_test("tie_break");
        load_layer2(1'b1, 1'b1);
        run_and_check('{mult: 16'd100, shift: 5'd16}, 0);
        check_eq("tie class_idx", 0, got_idx);
        check_eq("tie class_val", tie_bias, got_val);
        finish_test();

        begin_test("busy_lockout");
        load_act();
        load_layer2(1'b0, 1'b0);
        run_and_check('{mult: 16'd100, shift: 5'd16}, 200);
        finish_test();

        // Second start goes out on the edge right after done
        begin_test("back_to_back");
        load_act();
        run_and_check('{mult: 16'd100, shift: 5'd16}, 0);
        run_and_check('{mult: 16'd300, shift: 5'd17}, 0);
        finish_test();

        $display("Tests run: %0d, with errors: %0d, errors in total: %0d",
                 tests_run, tests_bad, total_errs);
        if (tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
// Free-running 8 ns clock; reset is high from time zero until the fourth rising edge
`timescale 1ns/1ns
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Released with a non-blocking update so the edge sees reset still high
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- hw/mnist_accel_top.sv
// Host holds i_requant stable while busy; writes during busy are ignored
`timescale 1ns/1ns
module mnist_accel_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mnist_pkg::host_wr_t     i_host_wr,
    input  logic                    i_start,
    input  mnist_pkg::requant_cfg_t i_requant,
    output logic                    o_busy,
    output logic                    o_done,
    output logic [3:0]              o_class_idx,
    output logic signed [31:0]      o_class_val
);
    logic [5:0]             act_addr;
    logic [9:0]             w1_addr;
    logic [6:0]             b1_addr;
    logic [6:0]             w2_addr;
    logic [3:0]             b2_addr;
    logic [7:0]             act;
    mnist_pkg::lane_bytes_t w1;
    mnist_pkg::lane_bytes_t w2;
    mnist_pkg::lane_bytes_t wts;
    logic [31:0]            b1;
    logic [31:0]            b2;
    logic                   load;
    logic [3:0]             load_lane;
    logic [31:0]            bias;
    logic                   mac;
    logic [7:0]             mac_act;
    logic                   sel_l2;
    logic                   q_start;
    logic                   q_valid;
    mnist_pkg::lane_bytes_t q;
    logic                   scan_start;
    mnist_pkg::lane_acc_t   acc;

    // Layer 2 reuses the array with the W2 banks
    assign wts = sel_l2 ? w2 : w1;

    param_store u_param_store (
        .clk        (clk),
        .i_host_wr  (i_host_wr),
        .i_busy     (o_busy),
        .i_act_addr (act_addr),
        .i_w1_addr  (w1_addr),
        .i_b1_addr  (b1_addr),
        .i_w2_addr  (w2_addr),
        .i_b2_addr  (b2_addr),
        .o_act      (act),
        .o_w1       (w1),
        .o_b1       (b1),
        .o_w2       (w2),
        .o_b2       (b2)
    );

    layer_sequencer u_seq (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .i_act        (act),
        .i_b1         (b1),
        .i_b2         (b2),
        .i_q_valid    (q_valid),
        .i_q          (q),
        .i_scan_done  (o_done),
        .o_busy       (o_busy),
        .o_act_addr   (act_addr),
        .o_w1_addr    (w1_addr),
        .o_b1_addr    (b1_addr),
        .o_w2_addr    (w2_addr),
        .o_b2_addr    (b2_addr),
        .o_load       (load),
        .o_load_lane  (load_lane),
        .o_bias       (bias),
        .o_mac        (mac),
        .o_mac_act    (mac_act),
        .o_sel_l2     (sel_l2),
        .o_q_start    (q_start),
        .o_scan_start (scan_start)
    );

    mac_array u_mac (
        .clk         (clk),
        .reset       (reset),
        .i_load      (load),
        .i_load_lane (load_lane),
        .i_bias      (bias),
        .i_mac       (mac),
        .i_act       (mac_act),
        .i_wts       (wts),
        .o_acc       (acc)
    );

    requant_relu u_rq (
        .clk     (clk),
        .reset   (reset),
        .i_valid (q_start),
        .i_acc   (acc),
        .i_cfg   (i_requant),
        .o_valid (q_valid),
        .o_q     (q)
    );

    argmax_scan u_argmax (
        .clk         (clk),
        .reset       (reset),
        .i_start     (scan_start),
        .i_logits    (acc),
        .o_done      (o_done),
        .o_class_idx (o_class_idx),
        .o_class_val (o_class_val)
    );

endmodule

//--- hw/argmax_scan.sv
// Done comes eleven cycles after i_start; ties keep the lower class index
`timescale 1ns/1ns
module argmax_scan (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_start,
    input  mnist_pkg::lane_acc_t i_logits,
    output logic                 o_done,
    output logic [3:0]           o_class_idx,
    output logic signed [31:0]   o_class_val
);
    logic                 run;
    logic [3:0]           pos;
    mnist_pkg::lane_acc_t logits;
    logic [3:0]           best_idx;
    logic signed [31:0]   best_val;
    logic signed [31:0]   cur;
    logic                 take;

    assign cur  = $signed(logits[pos]);
    // Strict compare, so an equal later logit never wins
    assign take = (pos == 4'd0) || (cur > best_val);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run         <= 1'b0;
            pos         <= '0;
            o_done      <= 1'b0;
            o_class_idx <= '0;
            o_class_val <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                run <= 1'b1;
                pos <= '0;
            end else if (run) begin
                pos <= pos + 4'd1;
                if (pos == 4'(mnist_pkg::LANES - 1)) begin
                    run         <= 1'b0;
                    o_done      <= 1'b1;
                    o_class_idx <= take ? pos : best_idx;
                    o_class_val <= take ? cur : best_val;
                end
            end
        end
    end

    // Captured logits and running best
    always_ff @(posedge clk) begin
        if (i_start) begin
            logits <= i_logits;
        end
        if (run && take) begin
            best_val <= cur;
            best_idx <= pos;
        end
    end

endmodule

//--- hw/layer_sequencer.sv
// Schedule relies on one-cycle RAM reads and three-cycle requant; i_start ignored while busy
`timescale 1ns/1ns
module layer_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_start,
    input  logic [7:0]             i_act,
    input  logic [31:0]            i_b1,
    input  logic [31:0]            i_b2,
    input  logic                   i_q_valid,
    input  mnist_pkg::lane_bytes_t i_q,
    input  logic                   i_scan_done,
    output logic                   o_busy,
    output logic [5:0]             o_act_addr,
    output logic [9:0]             o_w1_addr,
    output logic [6:0]             o_b1_addr,
    output logic [6:0]             o_w2_addr,
    output logic [3:0]             o_b2_addr,
    output logic                   o_load,
    output logic [3:0]             o_load_lane,
    output logic [31:0]            o_bias,
    output logic                   o_mac,
    output logic [7:0]             o_mac_act,
    output logic                   o_sel_l2,
    output logic                   o_q_start,
    output logic                   o_scan_start
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_L1_BIAS,
        S_L1_MAC,
        S_RQ_WAIT,
        S_NEXT_TILE,
        S_L2_BIAS,
        S_L2_MAC,
        S_SCAN_WAIT
    } state_t;

    state_t     state;
    logic [6:0] cnt;
    logic [3:0] tile_cnt;
    logic [6:0] tile_base;
    logic [7:0] hidden [mnist_pkg::K_L2];
    logic [7:0] hid_q;
    logic       bias_phase;
    logic       mac_phase;

    // --------------------
    // Control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            cnt      <= '0;
            tile_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state    <= S_L1_BIAS;
                        cnt      <= '0;
                        tile_cnt <= '0;
                    end
                end
                S_L1_BIAS, S_L2_BIAS: begin
                    // Ten address cycles plus one for the last read
                    if (cnt == 7'(mnist_pkg::LANES)) begin
                        state <= (state == S_L1_BIAS) ? S_L1_MAC : S_L2_MAC;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 7'd1;
                    end
                end
                S_L1_MAC: begin
                    if (cnt == 7'(mnist_pkg::K_L1)) begin
                        state <= S_RQ_WAIT;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 7'd1;
                    end
                end
                S_RQ_WAIT: begin
                    cnt <= 7'd1;
                    if (i_q_valid) begin
                        state <= S_NEXT_TILE;
                        cnt   <= '0;
                    end
                end
                S_NEXT_TILE: begin
                    if (tile_cnt == 4'(mnist_pkg::NUM_TILES - 1)) begin
                        state <= S_L2_BIAS;
                    end else begin
                        state    <= S_L1_BIAS;
                        tile_cnt <= tile_cnt + 4'd1;
                    end
                end
                S_L2_MAC: begin
                    if (cnt == 7'(mnist_pkg::K_L2)) begin
                        state <= S_SCAN_WAIT;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 7'd1;
                    end
                end
                S_SCAN_WAIT: begin
                    cnt <= 7'd1;
                    if (i_scan_done) begin
                        state <= S_IDLE;
                        cnt   <= '0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // --------------------
    // Hidden buffer holds tile t in bytes t*10 .. t*10+9
    always_ff @(posedge clk) begin
        if (state == S_RQ_WAIT && i_q_valid) begin
            for (int j = 0; j < mnist_pkg::LANES; j++) begin
                hidden[tile_base + 7'(j)] <= i_q[j];
            end
        end
        // Registered like the RAMs so it lines up with W2 data
        if (cnt < 7'(mnist_pkg::K_L2)) begin
            hid_q <= hidden[cnt];
        end
    end

    // --------------------
    // Addresses and array strobes
    assign tile_base  = {3'b0, tile_cnt} * 7'd10;
    assign o_act_addr = cnt[5:0];
    assign o_w1_addr  = {tile_cnt, cnt[5:0]};
    assign o_b1_addr  = tile_base + cnt;
    assign o_w2_addr  = cnt;
    assign o_b2_addr  = cnt[3:0];

    assign bias_phase   = (state == S_L1_BIAS) || (state == S_L2_BIAS);
    assign mac_phase    = (state == S_L1_MAC) || (state == S_L2_MAC);
    assign o_sel_l2     = (state == S_L2_BIAS) || (state == S_L2_MAC);

    // Data for address cnt-1 is on the RAM outputs now
    assign o_load       = bias_phase && (cnt != 7'd0);
    assign o_load_lane  = cnt[3:0] - 4'd1;
    assign o_bias       = o_sel_l2 ? i_b2 : i_b1;
    assign o_mac        = mac_phase && (cnt != 7'd0);
    assign o_mac_act    = o_sel_l2 ? hid_q : i_act;

    // Last MAC has landed by the first wait cycle
    assign o_q_start    = (state == S_RQ_WAIT) && (cnt == 7'd0);
    assign o_scan_start = (state == S_SCAN_WAIT) && (cnt == 7'd0);

    // Busy drops in the same cycle as done
    assign o_busy = (state != S_IDLE) && !((state == S_SCAN_WAIT) && i_scan_done);

    // A requant vector outside the wait state would never reach the hidden buffer
    a_q_in_wait: assert property (@(posedge clk) disable iff (reset)
        i_q_valid |-> (state == S_RQ_WAIT));

    // A scan result outside the scan wait would leave the FSM stuck
    a_done_in_scan: assert property (@(posedge clk) disable iff (reset)
        i_scan_done |-> (state == S_SCAN_WAIT));

endmodule

//--- hw/requant_relu.sv
// Fixed three-cycle latency, no stall; i_cfg must stay stable while vectors are in flight
`timescale 1ns/1ns
module requant_relu (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_valid,
    input  mnist_pkg::lane_acc_t      i_acc,
    input  mnist_pkg::requant_cfg_t   i_cfg,
    output logic                      o_valid,
    output mnist_pkg::lane_bytes_t    o_q
);
    logic [2:0]         vld_sr;
    logic signed [31:0] relu_q  [mnist_pkg::LANES];
    logic signed [47:0] prod_q  [mnist_pkg::LANES];
    logic signed [47:0] shifted [mnist_pkg::LANES];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[1:0], i_valid};
        end
    end

    assign o_valid = vld_sr[2];

    // Operand is non-negative after ReLU, so only the top needs a clamp
    always_comb begin
        for (int i = 0; i < mnist_pkg::LANES; i++) begin
            shifted[i] = prod_q[i] >>> i_cfg.shift;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < mnist_pkg::LANES; i++) begin
            // Stage 1: ReLU
            relu_q[i] <= i_acc[i][31] ? 32'sd0 : $signed(i_acc[i]);
            // Stage 2: 48 bits keep the full product
            prod_q[i] <= relu_q[i] * $signed({1'b0, i_cfg.mult});
            // Stage 3: shift and saturate
            o_q[i]    <= (shifted[i] > 48'sd255) ? 8'd255 : shifted[i][7:0];
        end
    end

endmodule

//--- hw/mac_array.sv
// Products are unsigned activation times signed weight; loads take priority over nothing
`timescale 1ns/1ns
module mac_array (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_load,
    input  logic [3:0]             i_load_lane,
    input  logic [31:0]            i_bias,
    input  logic                   i_mac,
    input  logic [7:0]             i_act,
    input  mnist_pkg::lane_bytes_t i_wts,
    output mnist_pkg::lane_acc_t   o_acc
);
    logic signed [15:0] prod [mnist_pkg::LANES];

    // 255 * -128 still fits in 16 signed bits
    always_comb begin
        for (int i = 0; i < mnist_pkg::LANES; i++) begin
            prod[i] = $signed({1'b0, i_act}) * $signed(i_wts[i]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_acc <= '0;
        end else if (i_load) begin
            // Bias preload, one lane per cycle
            o_acc[i_load_lane] <= i_bias;
        end else if (i_mac) begin
            for (int i = 0; i < mnist_pkg::LANES; i++) begin
                o_acc[i] <= o_acc[i] + {{16{prod[i][15]}}, prod[i]};
            end
        end
    end

    // A load in the same cycle as a MAC would drop the product
    a_load_mac_excl: assert property (@(posedge clk) disable iff (reset)
        !(i_load && i_mac));

endmodule

//--- hw/param_store.sv
// Host writes are dropped while busy; sequencer owns every address while busy
`timescale 1ns/1ns
module param_store (
    input  logic                   clk,
    input  mnist_pkg::host_wr_t    i_host_wr,
    input  logic                   i_busy,
    input  logic [5:0]             i_act_addr,
    input  logic [9:0]             i_w1_addr,
    input  logic [6:0]             i_b1_addr,
    input  logic [6:0]             i_w2_addr,
    input  logic [3:0]             i_b2_addr,
    output logic [7:0]             o_act,
    output mnist_pkg::lane_bytes_t o_w1,
    output logic [31:0]            o_b1,
    output mnist_pkg::lane_bytes_t o_w2,
    output logic [31:0]            o_b2
);
    logic [7:0]                  host_page;
    logic                        host_we;
    logic                        act_we;
    logic                        b1_we;
    logic                        b2_we;
    logic [mnist_pkg::LANES-1:0] w1_we;
    logic [mnist_pkg::LANES-1:0] w2_we;

    // --------------------
    // Window decode
    assign host_page = i_host_wr.addr[19:12];
    assign host_we   = i_host_wr.wren && !i_busy;
    assign act_we    = host_we && (host_page == mnist_pkg::ACT_H_BASE[19:12]);
    assign b1_we     = host_we && (host_page == mnist_pkg::B1_H_BASE[19:12]);
    assign b2_we     = host_we && (host_page == mnist_pkg::B2_H_BASE[19:12]);

    spram #(.data_t(logic [7:0]), .DEPTH(64)) u_act (
        .clk    (clk),
        .i_addr (i_busy ? i_act_addr : i_host_wr.addr[5:0]),
        .i_wren (act_we),
        .i_data (i_host_wr.data[7:0]),
        .o_data (o_act)
    );

    spram #(.data_t(logic [31:0]), .DEPTH(128)) u_b1 (
        .clk    (clk),
        .i_addr (i_busy ? i_b1_addr : i_host_wr.addr[6:0]),
        .i_wren (b1_we),
        .i_data (i_host_wr.data),
        .o_data (o_b1)
    );

    spram #(.data_t(logic [31:0]), .DEPTH(16)) u_b2 (
        .clk    (clk),
        .i_addr (i_busy ? i_b2_addr : i_host_wr.addr[3:0]),
        .i_wren (b2_we),
        .i_data (i_host_wr.data),
        .o_data (o_b2)
    );

    // --------------------
    // One weight bank per lane, one page per bank
    for (genvar b = 0; b < mnist_pkg::LANES; b++) begin : g_bank
        assign w1_we[b] = host_we && (host_page == mnist_pkg::W1_H_BASE[19:12] + 8'(b));
        assign w2_we[b] = host_we && (host_page == mnist_pkg::W2_H_BASE[19:12] + 8'(b));

        spram #(.data_t(logic [7:0]), .DEPTH(1024)) u_w1 (
            .clk    (clk),
            .i_addr (i_busy ? i_w1_addr : i_host_wr.addr[9:0]),
            .i_wren (w1_we[b]),
            .i_data (i_host_wr.data[7:0]),
            .o_data (o_w1[b])
        );

        spram #(.data_t(logic [7:0]), .DEPTH(128)) u_w2 (
            .clk    (clk),
            .i_addr (i_busy ? i_w2_addr : i_host_wr.addr[6:0]),
            .i_wren (w2_we[b]),
            .i_data (i_host_wr.data[7:0]),
            .o_data (o_w2[b])
        );
    end

endmodule

//--- hw/spram.sv
// Read data appears one cycle after the address; a write returns the old word
`timescale 1ns/1ns
module spram #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] i_addr,
    input  logic                     i_wren,
    input  data_t                    i_data,
    output data_t                    o_data
);
    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_wren) begin
            mem[i_addr] <= i_data;
        end
        o_data <= mem[i_addr];
    end

endmodule

//--- hw/mnist_pkg.sv
// Sizes are fixed for a 64-100-10 network; every host window is one 4 KB page
package mnist_pkg;

    // --------------------
    // Network sizes
    localparam int LANES     = 10;
    localparam int K_L1      = 64;
    localparam int K_L2      = 100;
    localparam int NUM_TILES = 10;

    // --------------------
    // Host address windows, page selected by addr[19:12]
    localparam logic [19:0] ACT_H_BASE = 20'h00000;
    // Bank b sits at W1_H_BASE + b * 4K, word address tile * 64 + k
    localparam logic [19:0] W1_H_BASE  = 20'h01000;
    localparam logic [19:0] B1_H_BASE  = 20'h0B000;
    // Bank c sits at W2_H_BASE + c * 4K, word address k
    localparam logic [19:0] W2_H_BASE  = 20'h0C000;
    localparam logic [19:0] B2_H_BASE  = 20'h16000;

    // --------------------
    // Shared types
    typedef struct packed {
        logic        wren;
        logic [19:0] addr;
        logic [31:0] data;
    } host_wr_t;

    // Unsigned multiplier, then arithmetic right shift
    typedef struct packed {
        logic [15:0] mult;
        logic [4:0]  shift;
    } requant_cfg_t;

    // One byte per lane
    typedef logic [LANES-1:0][7:0] lane_bytes_t;

    // One signed 32-bit value per lane
    typedef logic [LANES-1:0][31:0] lane_acc_t;

endpackage
